//--- common/vic_bus_pkg.sv
`default_nettype none

package vic_bus_pkg;

   // lines on which a character fetch may happen
   localparam logic [8:0] BADLINE_FIRST = 9'd48;
   localparam logic [8:0] BADLINE_LAST  = 9'd247;

   // chars ba window in cycle numbers, index is the chip code
   localparam logic [3:0][6:0] CHARS_BA_FIRST = {7'd11, 7'd11, 7'd12, 7'd12};
   localparam logic [3:0][6:0] CHARS_BA_LAST  = {7'd53, 7'd53, 7'd54, 7'd54};

   // cpu owns the bus, three warning cycles, then the vic takes it
   typedef enum logic [2:0] {
      BUS_CPU   = 3'd0,
      BUS_WARN1 = 3'd1,
      BUS_WARN2 = 3'd2,
      BUS_WARN3 = 3'd3,
      BUS_VIC   = 3'd4
   } bus_state_t;

   // dram strobe edges inside a phi half
   localparam logic [3:0] RAS_FALL_TICK    = 4'd2;
   localparam logic [3:0] CAS_FALL_TICK    = 4'd4;
   localparam logic [3:0] STROBE_RISE_TICK = 4'd14;

   // msb is tick 0, a one keeps the strobe high on that tick
   localparam logic [15:0] RAS_PROFILE =
      ~(16'hffff >> RAS_FALL_TICK) | (16'hffff >> STROBE_RISE_TICK);
   localparam logic [15:0] CAS_PROFILE =
      ~(16'hffff >> CAS_FALL_TICK) | (16'hffff >> STROBE_RISE_TICK);

endpackage : vic_bus_pkg

`default_nettype wire

//--- common/vic_timing_pkg.sv
`default_nettype none

package vic_timing_pkg;

   // chip model select, unused code runs as a 6569
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2,
      CHIP_UNUSED   = 2'd3
   } chip_t;

   // beam coordinates
   typedef logic [9:0] raster_x_t;
   typedef logic [8:0] raster_y_t;
   typedef logic [6:0] cycle_t;

   // last pixel and last line per chip, index is chip_t
   localparam logic [3:0][9:0] RASTER_X_MAX = {10'd503, 10'd503, 10'd511, 10'd519};
   localparam logic [3:0][8:0] RASTER_Y_MAX = {9'd311, 9'd311, 9'd261, 9'd262};

   // dot4x ticks in one phi half and in one pixel
   localparam int PHASE_TICKS = 16;
   localparam int DOT_TICKS   = 4;

   // ring start values, phi starts in its low half
   localparam logic [2*PHASE_TICKS-1:0] PHI_RING_INIT =
      {{PHASE_TICKS{1'b1}}, {PHASE_TICKS{1'b0}}};
   localparam logic [PHASE_TICKS-1:0] PHASE_RING_INIT = PHASE_TICKS'(1);
   localparam logic [DOT_TICKS-1:0]   DOT_RING_INIT   = DOT_TICKS'(1);

   // 8 pixels per cycle
   localparam int CYCLE_SHIFT    = 3;
   localparam int IRQ_CHECK_TICK = 3;
   localparam int BUS_STEP_TICK  = PHASE_TICKS - 1;

endpackage : vic_timing_pkg

`default_nettype wire

//--- dv/vic_timing_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vic_timing_tb;
   import vic_timing_pkg::*;
   import vic_bus_pkg::*;

   logic      clk_dot4x;
   logic      rst;
   chip_t     chip_i;
   logic [2:0] yscroll_i;
   logic      den_i;
   raster_y_t raster_irq_compare_i;
   logic      erst_i;
   logic      irst_clr_i;
   logic      phi_o;
   logic      ras_o;
   logic      cas_o;
   raster_x_t raster_x_o;
   raster_y_t raster_line_o;
   logic      irq_o;
   logic      ba_o;
   logic      aec_o;
   logic      badline_o;

   // reference beam and bus model holding the values of the current tick
   int   m_t, m_x, m_line, m_line_d, m_ysq, m_st;
   logic m_gate, m_trig, m_latch, m_aec, e_ba;
   // limits of the chip under test
   int   lim_x, lim_y, win_lo, win_hi, c_cmp, c_tpl, c_lpf;
   // observed counts
   int   prev_x, prev_line, last_wrap, wrap_count, ba_falls;
   logic prev_ba, frame_done, s_irq;
   int   s_line;
   // input values for the next tick
   logic erst_want, clr_want;

   vic_timing_top DUT (
      .clk_dot4x            (clk_dot4x),
      .rst                  (rst),
      .chip_i               (chip_i),
      .yscroll_i            (yscroll_i),
      .den_i                (den_i),
      .raster_irq_compare_i (raster_irq_compare_i),
      .erst_i               (erst_i),
      .irst_clr_i           (irst_clr_i),
      .phi_o                (phi_o),
      .ras_o                (ras_o),
      .cas_o                (cas_o),
      .raster_x_o           (raster_x_o),
      .raster_line_o        (raster_line_o),
      .irq_o                (irq_o),
      .ba_o                 (ba_o),
      .aec_o                (aec_o),
      .badline_o            (badline_o)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #4 clk_dot4x = ~clk_dot4x;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         fail_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
                            $time, name, actual, expected));
   endtask

   // 6567 chips fetch chars in cycles 12 to 54 and the 6569 and spare code in 11 to 53
   task automatic set_chip_limits(input int chip);
      case (chip)
         0: begin
            lim_x = 519;
            lim_y = 262;
         end
         1: begin
            lim_x = 511;
            lim_y = 261;
         end
         default: begin
            lim_x = 503;
            lim_y = 311;
         end
      endcase
      win_lo = (chip < 2) ? 12 : 11;
      win_hi = (chip < 2) ? 54 : 53;
   endtask

   // expected outputs of the current tick
   task automatic compare_outputs;
      int   h;
      int   cyc;
      logic e_phi, e_ras, e_cas, e_bad, e_irq;
      h     = m_t % 16;
      e_phi = (m_t % 32) >= 16;
      // strobes low from their fall tick until tick 14
      e_ras = (h < 2) || (h >= 14);
      e_cas = (h < 4) || (h >= 14);
      e_bad = m_gate && (m_line_d >= 48) && (m_line_d <= 247) && ((m_line_d % 8) == m_ysq);
      cyc   = m_x / 8;
      e_ba  = !(e_bad && (cyc >= win_lo) && (cyc <= win_hi));
      e_irq = m_latch && erst_i;
      if ({phi_o, ras_o, cas_o, badline_o, ba_o, irq_o, aec_o} !==
          {e_phi, e_ras, e_cas, e_bad, e_ba, e_irq, m_aec} ||
          raster_x_o !== m_x || raster_line_o !== m_line) begin
         check_value("phi_o", phi_o, e_phi);
         check_value("ras_o", ras_o, e_ras);
         check_value("cas_o", cas_o, e_cas);
         check_value("raster_x_o", raster_x_o, m_x);
         check_value("raster_line_o", raster_line_o, m_line);
         check_value("badline_o", badline_o, e_bad);
         check_value("ba_o", ba_o, e_ba);
         check_value("irq_o", irq_o, e_irq);
         check_value("aec_o", aec_o, m_aec);
      end
   endtask

   // register updates at the edge that ends the current tick
   task automatic advance_model;
      int   h, n_x, n_line, n_line_d, n_ysq, n_st;
      logic phi_e, n_gate, n_trig, n_latch, trig, match;
      h        = m_t % 16;
      phi_e    = (m_t % 32) >= 16;
      n_x      = m_x;
      n_line   = m_line;
      n_line_d = m_line_d;
      n_ysq    = m_ysq;
      n_gate   = m_gate;
      n_trig   = m_trig;
      n_st     = m_st;
      trig     = 1'b0;
      // one pixel every fourth tick
      if (m_t % 4 == 0) begin
         if (m_x == lim_x) begin
            n_x    = 0;
            n_line = (m_line == lim_y) ? 0 : m_line + 1;
         end else begin
            n_x = m_x + 1;
         end
      end
      // phi rise
      if (phi_e && h == 0) begin
         n_line_d = m_line;
         n_ysq    = yscroll_i;
         if (m_line == 48 && den_i)
            n_gate = 1'b1;
         if (m_line == 248)
            n_gate = 1'b0;
      end
      // irq compare once per line at tick 3 of the high half
      if (phi_e && h == 3) begin
         match  = (m_line_d == c_cmp);
         trig   = match && !m_trig;
         n_trig = match;
      end
      n_latch = trig || (m_latch && !irst_clr_i);
      // bus warning steps at the last tick of the high half
      if (phi_e && h == 15)
         n_st = e_ba ? 0 : ((m_st < 4) ? m_st + 1 : 4);
      m_aec    = phi_e && (m_st != 4);
      m_x      = n_x;
      m_line   = n_line;
      m_line_d = n_line_d;
      m_ysq    = n_ysq;
      m_gate   = n_gate;
      m_trig   = n_trig;
      m_latch  = n_latch;
      m_st     = n_st;
      m_t      = m_t + 1;
   endtask

   // sample at the falling edge and drive at the rising edge
   task automatic step_tick;
      @(negedge clk_dot4x);
      compare_outputs();
      if (raster_x_o == 0 && prev_x != 0) begin
         if (last_wrap >= 0)
            check_value("ticks per line", m_t - last_wrap, c_tpl);
         last_wrap  = m_t;
         wrap_count = wrap_count + 1;
      end
      if (raster_line_o == 0 && prev_line != 0) begin
         check_value("lines per frame", wrap_count, c_lpf);
         frame_done = 1'b1;
         wrap_count = 0;
      end
      if (!ba_o && prev_ba)
         ba_falls = ba_falls + 1;
      prev_x    = raster_x_o;
      prev_line = raster_line_o;
      prev_ba   = ba_o;
      s_irq     = irq_o;
      s_line    = raster_line_o;
      advance_model();
      @(posedge clk_dot4x);
      erst_i     <= erst_want;
      irst_clr_i <= clr_want;
   endtask

   task automatic run_case(input int chip, input int ys, input int den, input int cmp,
                           input int tpl, input int lpf);
      int k;
      int limit;
      set_chip_limits(chip);
      c_cmp = cmp;
      c_tpl = tpl;
      c_lpf = lpf;
      erst_want = 1'b0;
      clr_want  = 1'b0;
      @(posedge clk_dot4x);
      rst                  <= 1'b1;
      chip_i               <= chip_t'(chip);
      yscroll_i            <= ys[2:0];
      den_i                <= den[0];
      raster_irq_compare_i <= cmp[8:0];
      erst_i               <= 1'b0;
      irst_clr_i           <= 1'b0;
      repeat (2) @(posedge clk_dot4x);
      rst <= 1'b0;
      // tick 0 starts here
      m_t        = 0;
      m_x        = 0;
      m_line     = 0;
      m_line_d   = 0;
      m_ysq      = 0;
      m_st       = 0;
      m_gate     = 1'b0;
      m_trig     = 1'b0;
      m_latch    = 1'b0;
      m_aec      = 1'b0;
      prev_x     = 0;
      prev_line  = 0;
      prev_ba    = 1'b1;
      last_wrap  = -1;
      wrap_count = 0;
      ba_falls   = 0;
      frame_done = 1'b0;
      s_irq      = 1'b0;
      limit = lpf * tpl + 4 * tpl;
      // compare line of the first frame latches while the enable is low
      k = 0;
      while (!m_latch && k < limit) begin
         step_tick();
         k = k + 1;
      end
      if (!m_latch)
         fail_run("timeout: raster compare line was not reached in the first frame");
      repeat (40) step_tick();
      // late enable raises irq from the held latch
      erst_want = 1'b1;
      repeat (64) step_tick();
      clr_want = 1'b1;
      step_tick();
      clr_want = 1'b0;
      step_tick();
      step_tick();
      // irq must stay low until the compare line of the next frame
      k = 0;
      while (!s_irq && k < limit) begin
         step_tick();
         k = k + 1;
      end
      if (!s_irq)
         fail_run("timeout: raster interrupt did not return in the next frame");
      check_value("raster line at interrupt", s_line, cmp);
      if (!frame_done)
         fail_run("the line count of a frame was never measured");
      if (den != 0 && ba_falls == 0)
         fail_run("no badline bus request was seen with den set");
   endtask

   initial begin
      int fd, code, guard, cases;
      int chip, ys, den, cmp, tpl, lpf;
      logic [8*160-1:0] skipped;
      rst                  <= 1'b1;
      chip_i               <= CHIP_6569;
      yscroll_i            <= 3'd0;
      den_i                <= 1'b0;
      raster_irq_compare_i <= '0;
      erst_i               <= 1'b0;
      irst_clr_i           <= 1'b0;
      cases = 0;
      guard = 0;
      fd = $fopen("dv/vic_timing_tests.txt", "r");
      if (fd == 0)
         fail_run("could not open the test file dv/vic_timing_tests.txt");
      while (!$feof(fd) && guard < 256) begin
         code = $fscanf(fd, "%d %d %d %d %d %d", chip, ys, den, cmp, tpl, lpf);
         if (code == 6) begin
            run_case(chip, ys, den, cmp, tpl, lpf);
            cases = cases + 1;
         end else begin
            // comment line or stray text
            code = $fgets(skipped, fd);
         end
         guard = guard + 1;
      end
      $fclose(fd);
      if (cases == 0) begin
         fail_run("no test case was read from the test file");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule : vic_timing_tb

`default_nettype wire

//--- dv/vic_timing_tests.txt
# columns: chip yscroll den compare_line ticks_per_line lines_per_frame
# chip codes: 0 = 6567R8, 1 = 6567R56A, 2 = 6569, 3 = unused (runs as 6569)
0 3 1 20 2080 263
1 0 1 51 2048 262
2 7 1 9 2016 312
3 5 1 33 2016 312
2 3 0 60 2016 312

//--- raster/raster_counter.sv
`timescale 1ns/1ps
`default_nettype none

module raster_counter (
   input  logic                      clk_dot4x,
   input  logic                      rst,
   input  vic_timing_pkg::chip_t     chip_i,
   input  logic                      dot_en_i,
   input  logic                      phi_rise_i,
   output vic_timing_pkg::raster_x_t raster_x_o,
   output vic_timing_pkg::raster_y_t raster_line_o,
   output vic_timing_pkg::raster_y_t raster_line_d_o
);
   import vic_timing_pkg::*;

   raster_x_t x_max;
   raster_y_t y_max;
   raster_x_t raster_x;
   raster_y_t raster_line;
   raster_y_t raster_line_d;
   logic      x_wrap;

   // model limits only change while in reset
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         x_max <= RASTER_X_MAX[chip_i];
         y_max <= RASTER_Y_MAX[chip_i];
      end
   end

   assign x_wrap = (raster_x == x_max);

   // one pixel per dot enable
   // line steps when x wraps, frame ends after the last line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= '0;
         raster_line <= '0;
      end else if (dot_en_i) begin
         if (x_wrap) begin
            raster_x <= '0;
            if (raster_line == y_max)
               raster_line <= '0;
            else
               raster_line <= raster_line + 9'd1;
         end else begin
            raster_x <= raster_x + 10'd1;
         end
      end
   end

   // line as seen from the phi high half, used by irq and badline logic
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         raster_line_d <= '0;
      else if (phi_rise_i)
         raster_line_d <= raster_line;
   end

   assign raster_x_o      = raster_x;
   assign raster_line_o   = raster_line;
   assign raster_line_d_o = raster_line_d;

   a_x_in_range: assert property (
      @(posedge clk_dot4x) disable iff (rst) raster_x <= x_max
   );

endmodule : raster_counter

`default_nettype wire

//--- raster/raster_irq.sv
`timescale 1ns/1ps
`default_nettype none

module raster_irq (
   input  logic                      clk_dot4x,
   input  logic                      rst,
   input  logic                      check_i,
   input  vic_timing_pkg::raster_y_t raster_line_d_i,
   input  vic_timing_pkg::raster_y_t compare_i,
   input  logic                      erst_i,
   input  logic                      irst_clr_i,
   output logic                      irq_o
);

   logic match;
   logic triggered;
   logic trigger;
   logic irst;

   assign match   = (raster_line_d_i == compare_i);
   // only the first check of a matching line fires
   assign trigger = check_i && match && !triggered;

   // flag re-arms once a check sees a different line
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         triggered <= 1'b0;
      else if (check_i)
         triggered <= match;
   end

   // latch holds until cleared, a trigger on the clear tick wins
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         irst <= 1'b0;
      else
         irst <= trigger | (irst & ~irst_clr_i);
   end

   // condition is latched even when disabled, enabling later raises irq
   assign irq_o = irst & erst_i;

   a_clear_drops_latch: assert property (
      @(posedge clk_dot4x) disable iff (rst) (irst_clr_i && !trigger) |=> !irst
   );

endmodule : raster_irq

`default_nettype wire

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
   input  logic                                   clk_dot4x,
   input  logic                                   rst,
   input  vic_timing_pkg::chip_t                  chip_i,
   input  logic                                   phi_i,
   input  logic [vic_timing_pkg::PHASE_TICKS-1:0] phase_start_i,
   input  vic_timing_pkg::raster_x_t              raster_x_i,
   input  vic_timing_pkg::raster_y_t              raster_line_i,
   input  vic_timing_pkg::raster_y_t              raster_line_d_i,
   input  logic [2:0]                             yscroll_i,
   input  logic                                   den_i,
   output logic                                   ba_o,
   output logic                                   aec_o,
   output logic                                   badline_o
);
   import vic_timing_pkg::*;
   import vic_bus_pkg::*;

   chip_t      chip_q;
   logic       phi_rise;
   logic       bus_step;
   logic       allow_bad_lines;
   logic [2:0] yscroll_d;
   logic       badline;
   cycle_t     cycle_num;
   logic       in_chars_window;
   bus_state_t state;
   bus_state_t state_nxt;

   assign phi_rise = phi_i & phase_start_i[0];
   assign bus_step = phi_i & phase_start_i[BUS_STEP_TICK];

   always_ff @(posedge clk_dot4x) begin
      if (rst)
         chip_q <= chip_i;
   end

   // gate opens on line 48 if den is seen at any phi rise there
   // closes again on the first line past the badline range
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
         yscroll_d       <= '0;
      end else if (phi_rise) begin
         yscroll_d <= yscroll_i;
         if (raster_line_i == BADLINE_FIRST && den_i)
            allow_bad_lines <= 1'b1;
         if (raster_line_i == BADLINE_LAST + 9'd1)
            allow_bad_lines <= 1'b0;
      end
   end

   assign badline = (raster_line_d_i[2:0] == yscroll_d) && allow_bad_lines &&
                    (raster_line_d_i >= BADLINE_FIRST) && (raster_line_d_i <= BADLINE_LAST);

   // cycle number is raster_x over 8
   assign cycle_num       = cycle_t'(raster_x_i >> CYCLE_SHIFT);
   assign in_chars_window = (cycle_num >= CHARS_BA_FIRST[chip_q]) &&
                            (cycle_num <= CHARS_BA_LAST[chip_q]);

   assign badline_o = badline;
   assign ba_o      = !(badline && in_chars_window);

   // one warning step per phi cycle while ba is low
   always_comb begin
      state_nxt = state;
      if (bus_step) begin
         if (ba_o) begin
            state_nxt = BUS_CPU;
         end else begin
            case (state)
               BUS_CPU:   state_nxt = BUS_WARN1;
               BUS_WARN1: state_nxt = BUS_WARN2;
               BUS_WARN2: state_nxt = BUS_WARN3;
               BUS_WARN3: state_nxt = BUS_VIC;
               BUS_VIC:   state_nxt = BUS_VIC;
               default:   state_nxt = BUS_CPU;
            endcase
         end
      end
   end

   // aec tracks phi a tick late, held low once the vic owns the bus
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         state <= BUS_CPU;
         aec_o <= 1'b0;
      end else begin
         state <= state_nxt;
         aec_o <= (state == BUS_VIC) ? 1'b0 : phi_i;
      end
   end

   // cpu never sees the bus in a phi low half
   a_aec_low_with_phi: assert property (
      @(posedge clk_dot4x) disable iff (rst) (!phi_i && !$past(phi_i)) |-> !aec_o
   );

endmodule : bus_arbiter

`default_nettype wire

//--- rtl/phase_gen.sv
`timescale 1ns/1ps
`default_nettype none

module phase_gen (
   input  logic                                   clk_dot4x,
   input  logic                                   rst,
   output logic                                   phi_o,
   output logic [vic_timing_pkg::PHASE_TICKS-1:0] phase_start_o,
   output logic                                   dot_en_o,
   output logic                                   ras_o,
   output logic                                   cas_o
);
   import vic_timing_pkg::*;
   import vic_bus_pkg::*;

   logic [2*PHASE_TICKS-1:0] phi_ring;
   logic [PHASE_TICKS-1:0]   phase_ring;
   logic [DOT_TICKS-1:0]     dot_ring;
   logic [PHASE_TICKS-1:0]   ras_gen;
   logic [PHASE_TICKS-1:0]   cas_gen;
   logic                     half_end;

   // last tick of a half, phi flips on the next one
   assign half_end = phase_ring[PHASE_TICKS-1];

   // phi ring shifts right so bit 0 walks through the 32 tick period
   // phase and dot rings shift left, bit k marks tick k
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring   <= PHI_RING_INIT;
         phase_ring <= PHASE_RING_INIT;
         dot_ring   <= DOT_RING_INIT;
      end else begin
         phi_ring   <= {phi_ring[0], phi_ring[2*PHASE_TICKS-1:1]};
         phase_ring <= {phase_ring[PHASE_TICKS-2:0], phase_ring[PHASE_TICKS-1]};
         dot_ring   <= {dot_ring[DOT_TICKS-2:0], dot_ring[DOT_TICKS-1]};
      end
   end

   // strobe profiles reload for each half and drain out of the msb
   always_ff @(posedge clk_dot4x) begin
      if (rst || half_end) begin
         ras_gen <= RAS_PROFILE;
         cas_gen <= CAS_PROFILE;
      end else begin
         ras_gen <= {ras_gen[PHASE_TICKS-2:0], 1'b0};
         cas_gen <= {cas_gen[PHASE_TICKS-2:0], 1'b0};
      end
   end

   assign phi_o         = phi_ring[0];
   assign phase_start_o = phase_ring;
   assign dot_en_o      = dot_ring[0];
   assign ras_o         = ras_gen[PHASE_TICKS-1];
   assign cas_o         = cas_gen[PHASE_TICKS-1];

   // downstream strobes decode single bits of this ring
   a_phase_onehot: assert property (
      @(posedge clk_dot4x) disable iff (rst) $onehot(phase_ring)
   );

endmodule : phase_gen

`default_nettype wire

//--- rtl/vic_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_timing_top (
   input  logic                      clk_dot4x,
   input  logic                      rst,
   input  vic_timing_pkg::chip_t     chip_i,
   input  logic [2:0]                yscroll_i,
   input  logic                      den_i,
   input  vic_timing_pkg::raster_y_t raster_irq_compare_i,
   input  logic                      erst_i,
   input  logic                      irst_clr_i,
   output logic                      phi_o,
   output logic                      ras_o,
   output logic                      cas_o,
   output vic_timing_pkg::raster_x_t raster_x_o,
   output vic_timing_pkg::raster_y_t raster_line_o,
   output logic                      irq_o,
   output logic                      ba_o,
   output logic                      aec_o,
   output logic                      badline_o
);
   import vic_timing_pkg::*;

   logic [PHASE_TICKS-1:0] phase_start;
   logic                   dot_en;
   logic                   phi_rise;
   logic                   irq_check;
   raster_y_t              raster_line_d;

   // first tick of the phi high half, and the irq compare tick within it
   assign phi_rise  = phi_o & phase_start[0];
   assign irq_check = phi_o & phase_start[IRQ_CHECK_TICK];

   phase_gen u_phase_gen (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .phi_o         (phi_o),
      .phase_start_o (phase_start),
      .dot_en_o      (dot_en),
      .ras_o         (ras_o),
      .cas_o         (cas_o)
   );

   raster_counter u_raster_counter (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .chip_i          (chip_i),
      .dot_en_i        (dot_en),
      .phi_rise_i      (phi_rise),
      .raster_x_o      (raster_x_o),
      .raster_line_o   (raster_line_o),
      .raster_line_d_o (raster_line_d)
   );

   raster_irq u_raster_irq (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .check_i         (irq_check),
      .raster_line_d_i (raster_line_d),
      .compare_i       (raster_irq_compare_i),
      .erst_i          (erst_i),
      .irst_clr_i      (irst_clr_i),
      .irq_o           (irq_o)
   );

   bus_arbiter u_bus_arbiter (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .chip_i          (chip_i),
      .phi_i           (phi_o),
      .phase_start_i   (phase_start),
      .raster_x_i      (raster_x_o),
      .raster_line_i   (raster_line_o),
      .raster_line_d_i (raster_line_d),
      .yscroll_i       (yscroll_i),
      .den_i           (den_i),
      .ba_o            (ba_o),
      .aec_o           (aec_o),
      .badline_o       (badline_o)
   );

endmodule : vic_timing_top

`default_nettype wire

//--- vic_timing_top.f
common/vic_timing_pkg.sv
common/vic_bus_pkg.sv
rtl/phase_gen.sv
raster/raster_counter.sv
raster/raster_irq.sv
rtl/bus_arbiter.sv
rtl/vic_timing_top.sv
dv/vic_timing_tb.sv
